// File: src/rvPkg.sv
package rvPkg;

   // Datapath and memory sizes
   localparam int XLEN       = 32;
   localparam int PC_W       = 12;
   localparam int REG_AW     = 5;
   localparam int NUM_REGS   = 32;
   localparam int IMEM_DEPTH = 1024;
   localparam int DMEM_DEPTH = 1024;

   localparam logic [PC_W-1:0] PC_STEP = 4;

   // Major opcodes of the supported subset
   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_AUIPC  = 7'b0010111;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_JAL    = 7'b1101111;
   localparam logic [6:0] OP_JALR   = 7'b1100111;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;

   // funct3 for ALU ops, branches and word access
   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;
   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_WORD = 3'b010;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASSB
   } aluOpT;

   // Which value writeback puts into rd
   typedef enum logic [1:0] {
      DEST_NONE, DEST_ALU, DEST_MEM, DEST_LINK
   } destT;

   // Decoder output inside execute
   typedef struct packed {
      aluOpT aluOp;
      destT  dest;
      logic  useImm;
      logic  usePc;
      logic  isBranch;
      logic  isJal;
      logic  isJalr;
      logic  isLoad;
      logic  isStore;
   } ctrlT;

   localparam ctrlT CTRL_NOP = '{aluOp: ALU_ADD, dest: DEST_NONE, default: 1'b0};

   typedef struct packed {
      logic              valid;
      destT              dest;
      logic [REG_AW-1:0] rd;
      logic [XLEN-1:0]   aluOut;
      logic [XLEN-1:0]   link;
   } exResultT;

endpackage

// File: src/fetchIf.sv
interface fetchIf;

   logic                   valid;
   logic [rvPkg::PC_W-1:0] pc;
   logic [rvPkg::XLEN-1:0] instr;

   // Taken branch or jump resolved in execute
   logic                   redirect;
   logic [rvPkg::PC_W-1:0] redirectPc;

   modport fetch (
      output valid, pc, instr,
      input  redirect, redirectPc
   );

   modport execute (
      input  valid, pc, instr,
      output redirect, redirectPc
   );

endinterface

// File: src/fetchUnit.sv
module fetchUnit (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   stall,
   input  logic                   imemWe,
   input  logic [rvPkg::PC_W-1:0] imemAddr,
   input  logic [rvPkg::XLEN-1:0] imemWdata,
   fetchIf.fetch                  fi
);

   logic [rvPkg::XLEN-1:0] imem [rvPkg::IMEM_DEPTH];

   // Address being read from imem this cycle
   logic [rvPkg::PC_W-1:0] fetchPc;
   logic [rvPkg::PC_W-1:0] nextPc;

   assign nextPc = fi.redirect ? fi.redirectPc : fetchPc + rvPkg::PC_STEP;

   // Program load port, only open while reset is held
   always_ff @(posedge clk)
   begin
      if (rst && imemWe)
      begin
         imem[imemAddr[rvPkg::PC_W-1:2]] <= imemWdata;
      end
   end

   // Synchronous read, word lands in execute next cycle
   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         fi.instr <= imem[fetchPc[rvPkg::PC_W-1:2]];
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         fetchPc  <= '0;
         fi.pc    <= '0;
         fi.valid <= 1'b0;
      end
      else if (!stall)
      begin
         fi.pc    <= fetchPc;
         // Word read alongside a redirect is wrong path
         fi.valid <= !fi.redirect;
         fetchPc  <= nextPc;
      end
   end

endmodule

// File: src/regFile.sv
module regFile (
   input  logic                     clk,
   input  logic [rvPkg::REG_AW-1:0] ra1,
   input  logic [rvPkg::REG_AW-1:0] ra2,
   output logic [rvPkg::XLEN-1:0]   rd1,
   output logic [rvPkg::XLEN-1:0]   rd2,
   input  logic                     we,
   input  logic [rvPkg::REG_AW-1:0] wa,
   input  logic [rvPkg::XLEN-1:0]   wd
);

   logic [rvPkg::XLEN-1:0] regs [rvPkg::NUM_REGS];

   always_ff @(posedge clk)
   begin
      if (we && wa != '0)
      begin
         regs[wa] <= wd;
      end
   end

   // x0 always reads zero
   assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// File: src/executeUnit.sv
module executeUnit (
   fetchIf.execute                  fi,
   output logic [rvPkg::REG_AW-1:0] ra1,
   output logic [rvPkg::REG_AW-1:0] ra2,
   input  logic [rvPkg::XLEN-1:0]   rd1,
   input  logic [rvPkg::XLEN-1:0]   rd2,
   input  logic                     wbEn,
   input  logic [rvPkg::REG_AW-1:0] wbAddr,
   input  logic [rvPkg::XLEN-1:0]   wbData,
   output rvPkg::exResultT          exResult,
   output logic [rvPkg::PC_W-1:0]   dmemAddr,
   output logic                     dmemWe,
   output logic                     dmemRe,
   output logic [rvPkg::XLEN-1:0]   dmemWdata
);

   logic [rvPkg::XLEN-1:0] instr;
   logic [2:0]             funct3;
   logic [rvPkg::XLEN-1:0] immI, immS, immB, immU, immJ, imm;
   rvPkg::ctrlT            ctrl;
   logic [rvPkg::XLEN-1:0] src1, src2, opA, opB, aluOut;
   logic                   taken;
   logic [rvPkg::PC_W-1:0] target;

   assign instr  = fi.instr;
   assign funct3 = instr[14:12];
   assign ra1    = instr[19:15];
   assign ra2    = instr[24:20];

   assign immI = {{20{instr[31]}}, instr[31:20]};
   assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immU = {instr[31:12], 12'b0};
   assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   // Decode; anything unrecognised stays a no-op
   always_comb
   begin
      ctrl = rvPkg::CTRL_NOP;
      imm  = immI;
      case (instr[6:0])
         rvPkg::OP_REG:
         begin
            ctrl.dest = rvPkg::DEST_ALU;
            case (funct3)
               rvPkg::F3_ADD: ctrl.aluOp = instr[30] ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
               rvPkg::F3_SLT: ctrl.aluOp = rvPkg::ALU_SLT;
               rvPkg::F3_XOR: ctrl.aluOp = rvPkg::ALU_XOR;
               rvPkg::F3_OR:  ctrl.aluOp = rvPkg::ALU_OR;
               rvPkg::F3_AND: ctrl.aluOp = rvPkg::ALU_AND;
               default:       ctrl.dest  = rvPkg::DEST_NONE;
            endcase
         end
         rvPkg::OP_IMM:
         begin
            ctrl.dest   = rvPkg::DEST_ALU;
            ctrl.useImm = 1'b1;
            case (funct3)
               rvPkg::F3_ADD: ctrl.aluOp = rvPkg::ALU_ADD;
               rvPkg::F3_XOR: ctrl.aluOp = rvPkg::ALU_XOR;
               rvPkg::F3_OR:  ctrl.aluOp = rvPkg::ALU_OR;
               rvPkg::F3_AND: ctrl.aluOp = rvPkg::ALU_AND;
               default:       ctrl.dest  = rvPkg::DEST_NONE;
            endcase
         end
         rvPkg::OP_LUI, rvPkg::OP_AUIPC:
         begin
            ctrl.dest   = rvPkg::DEST_ALU;
            ctrl.useImm = 1'b1;
            imm         = immU;
            // AUIPC adds to pc, LUI just passes the immediate
            ctrl.usePc  = (instr[6:0] == rvPkg::OP_AUIPC);
            ctrl.aluOp  = ctrl.usePc ? rvPkg::ALU_ADD : rvPkg::ALU_PASSB;
         end
         rvPkg::OP_BRANCH: ctrl.isBranch = 1'b1;
         rvPkg::OP_JAL:
         begin
            ctrl.dest  = rvPkg::DEST_LINK;
            ctrl.isJal = 1'b1;
         end
         rvPkg::OP_JALR:
         begin
            ctrl.dest   = rvPkg::DEST_LINK;
            ctrl.isJalr = 1'b1;
            ctrl.useImm = 1'b1;
         end
         rvPkg::OP_LOAD:
         begin
            if (funct3 == rvPkg::F3_WORD)
            begin
               ctrl.dest   = rvPkg::DEST_MEM;
               ctrl.isLoad = 1'b1;
               ctrl.useImm = 1'b1;
            end
         end
         rvPkg::OP_STORE:
         begin
            ctrl.isStore = (funct3 == rvPkg::F3_WORD);
            ctrl.useImm  = 1'b1;
            imm          = immS;
         end
         default: ctrl = rvPkg::CTRL_NOP;
      endcase
   end

   // Bypass from writeback covers every hazard, load-use included
   assign src1 = (wbEn && wbAddr == ra1 && wbAddr != '0) ? wbData : rd1;
   assign src2 = (wbEn && wbAddr == ra2 && wbAddr != '0) ? wbData : rd2;

   assign opA = ctrl.usePc ? {{(rvPkg::XLEN-rvPkg::PC_W){1'b0}}, fi.pc} : src1;
   assign opB = ctrl.useImm ? imm : src2;

   always_comb
   begin
      case (ctrl.aluOp)
         rvPkg::ALU_SUB:   aluOut = opA - opB;
         rvPkg::ALU_AND:   aluOut = opA & opB;
         rvPkg::ALU_OR:    aluOut = opA | opB;
         rvPkg::ALU_XOR:   aluOut = opA ^ opB;
         rvPkg::ALU_SLT:   aluOut = {31'b0, $signed(opA) < $signed(opB)};
         rvPkg::ALU_PASSB: aluOut = opB;
         default:          aluOut = opA + opB;
      endcase
   end

   always_comb
   begin
      case (funct3)
         rvPkg::F3_BEQ: taken = (src1 == src2);
         rvPkg::F3_BNE: taken = (src1 != src2);
         rvPkg::F3_BLT: taken = ($signed(src1) < $signed(src2));
         rvPkg::F3_BGE: taken = ($signed(src1) >= $signed(src2));
         default:       taken = 1'b0;
      endcase
      if (ctrl.isJalr)
      begin
         target = {aluOut[rvPkg::PC_W-1:1], 1'b0};
      end
      else if (ctrl.isJal)
      begin
         target = fi.pc + immJ[rvPkg::PC_W-1:0];
      end
      else
      begin
         target = fi.pc + immB[rvPkg::PC_W-1:0];
      end
   end

   assign fi.redirect   = fi.valid && ((ctrl.isBranch && taken) || ctrl.isJal || ctrl.isJalr);
   assign fi.redirectPc = target;

   assign exResult.valid  = fi.valid;
   assign exResult.dest   = ctrl.dest;
   assign exResult.rd     = instr[11:7];
   assign exResult.aluOut = aluOut;
   assign exResult.link   = {{(rvPkg::XLEN-rvPkg::PC_W){1'b0}}, fi.pc + rvPkg::PC_STEP};

   // Word access, byte address from the ALU
   assign dmemAddr  = aluOut[rvPkg::PC_W-1:0];
   assign dmemWe    = fi.valid && ctrl.isStore;
   assign dmemRe    = fi.valid && ctrl.isLoad;
   assign dmemWdata = src2;

endmodule

// File: src/writebackUnit.sv
module writebackUnit (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     stall,
   input  rvPkg::exResultT          exResult,
   input  logic [rvPkg::PC_W-1:0]   dmemAddr,
   input  logic                     dmemWe,
   input  logic                     dmemRe,
   input  logic [rvPkg::XLEN-1:0]   dmemWdata,
   output logic                     wbEn,
   output logic [rvPkg::REG_AW-1:0] wbAddr,
   output logic [rvPkg::XLEN-1:0]   wbData,
   output logic                     retireValid,
   output logic [rvPkg::REG_AW-1:0] retireRd,
   output logic [rvPkg::XLEN-1:0]   retireData
);

   logic [rvPkg::XLEN-1:0] dmem [rvPkg::DMEM_DEPTH];
   logic [rvPkg::XLEN-1:0] loadData;
   rvPkg::exResultT        wbReg;

   // Word addressed; load data lines up with wbReg
   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         if (dmemWe)
         begin
            dmem[dmemAddr[rvPkg::PC_W-1:2]] <= dmemWdata;
         end
         if (dmemRe)
         begin
            loadData <= dmem[dmemAddr[rvPkg::PC_W-1:2]];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wbReg.valid <= 1'b0;
      end
      else if (!stall)
      begin
         wbReg <= exResult;
      end
   end

   always_comb
   begin
      case (wbReg.dest)
         rvPkg::DEST_MEM:  wbData = loadData;
         rvPkg::DEST_LINK: wbData = wbReg.link;
         default:          wbData = wbReg.aluOut;
      endcase
   end

   // No write while frozen, and never to x0
   assign wbEn   = wbReg.valid && !stall && wbReg.dest != rvPkg::DEST_NONE && wbReg.rd != '0;
   assign wbAddr = wbReg.rd;

   assign retireValid = wbEn;
   assign retireRd    = wbAddr;
   assign retireData  = wbData;

endmodule

// File: src/riscvCore.sv
module riscvCore (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     stall,
   input  logic                     imemWe,
   input  logic [rvPkg::PC_W-1:0]   imemAddr,
   input  logic [rvPkg::XLEN-1:0]   imemWdata,
   output logic                     retireValid,
   output logic [rvPkg::REG_AW-1:0] retireRd,
   output logic [rvPkg::XLEN-1:0]   retireData
);

   logic [rvPkg::REG_AW-1:0] ra1, ra2;
   logic [rvPkg::XLEN-1:0]   rd1, rd2;
   logic                     wbEn;
   logic [rvPkg::REG_AW-1:0] wbAddr;
   logic [rvPkg::XLEN-1:0]   wbData;
   rvPkg::exResultT          exResult;
   logic [rvPkg::PC_W-1:0]   dmemAddr;
   logic                     dmemWe, dmemRe;
   logic [rvPkg::XLEN-1:0]   dmemWdata;

   fetchIf fi ();

   fetchUnit u_fetchUnit (
      .clk(clk), .rst(rst), .stall(stall),
      .imemWe(imemWe), .imemAddr(imemAddr), .imemWdata(imemWdata),
      .fi(fi.fetch)
   );

   regFile u_regFile (
      .clk(clk), .ra1(ra1), .ra2(ra2), .rd1(rd1), .rd2(rd2),
      .we(wbEn), .wa(wbAddr), .wd(wbData)
   );

   executeUnit u_executeUnit (
      .fi(fi.execute), .ra1(ra1), .ra2(ra2), .rd1(rd1), .rd2(rd2),
      .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData), .exResult(exResult),
      .dmemAddr(dmemAddr), .dmemWe(dmemWe), .dmemRe(dmemRe), .dmemWdata(dmemWdata)
   );

   writebackUnit u_writebackUnit (
      .clk(clk), .rst(rst), .stall(stall), .exResult(exResult),
      .dmemAddr(dmemAddr), .dmemWe(dmemWe), .dmemRe(dmemRe), .dmemWdata(dmemWdata),
      .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
      .retireValid(retireValid), .retireRd(retireRd), .retireData(retireData)
   );

endmodule

// File: dv/riscvCore_asserts.sv
module riscvCore_asserts (
   input logic                     clk,
   input logic                     rst,
   input logic                     stall,
   input logic                     redirect,
   input logic                     retireValid,
   input logic [rvPkg::REG_AW-1:0] retireRd
);

   // Reset clears the writeback register by the next edge
   assert property (@(posedge clk) rst |=> !retireValid)
      else $error("retire seen while the core is held in reset");

   assert property (@(posedge clk) stall |-> !retireValid)
      else $error("retire seen in a stalled cycle");

   assert property (@(posedge clk) disable iff (rst) retireValid |-> retireRd != '0)
      else $error("retire reported for register x0");

   // Wrong-path slot is squashed, so no second redirect
   assert property (@(posedge clk) disable iff (rst) (redirect && !stall) |=> !redirect)
      else $error("redirect held for two unstalled cycles");

endmodule

bind riscvCore riscvCore_asserts u_asserts (
   .clk(clk),
   .rst(rst),
   .stall(stall),
   .redirect(fi.redirect),
   .retireValid(retireValid),
   .retireRd(retireRd)
);

// File: dv/tbRiscvCore.sv
module tbRiscvCore;

   localparam int          RESET_CYCLES = 16;
   localparam logic [31:0] LFSR_SEED    = 32'h5ae0647a;
   // jal x0, 0 spins in place and retires nothing
   localparam logic [31:0] HALT         = 32'h0000006f;
   localparam logic [2:0]  ALU_F3 [5]   = '{rvPkg::F3_ADD, rvPkg::F3_SLT, rvPkg::F3_XOR,
                                            rvPkg::F3_OR, rvPkg::F3_AND};
   localparam logic [2:0]  BR_F3 [4]    = '{rvPkg::F3_BEQ, rvPkg::F3_BNE, rvPkg::F3_BLT,
                                            rvPkg::F3_BGE};

   logic                     clk;
   logic                     rst;
   logic                     stall;
   logic                     imemWe;
   logic [rvPkg::PC_W-1:0]   imemAddr;
   logic [rvPkg::XLEN-1:0]   imemWdata;
   logic                     retireValid;
   logic [rvPkg::REG_AW-1:0] retireRd;
   logic [rvPkg::XLEN-1:0]   retireData;

   logic [31:0] lfsr;
   logic [31:0] prog [rvPkg::IMEM_DEPTH];
   int          progLen;
   // Shadow architectural state, kept across programs like the DUT
   logic [31:0] mregs [32];
   logic [31:0] mdmem [rvPkg::DMEM_DEPTH];
   logic [4:0]  expRd [$];
   logic [31:0] expData [$];
   int          retired;

   riscvCore u_riscvCore (
      .clk(clk), .rst(rst), .stall(stall),
      .imemWe(imemWe), .imemAddr(imemAddr), .imemWdata(imemWdata),
      .retireValid(retireValid), .retireRd(retireRd), .retireData(retireData)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic failRun(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic compareValue(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      if (got !== exp)
         failRun($sformatf("ERROR at time %0t: %s is %h, expected %h", $time, name, got, exp));
   endtask

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic takeBit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] takeBits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[30:0], takeBit()};
      return v;
   endfunction

   function automatic logic [31:0] encR(input logic [2:0] f3, input logic sub,
                                        input logic [4:0] rd, rs1, rs2);
      return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, rvPkg::OP_REG};
   endfunction

   function automatic logic [31:0] encI(input logic [6:0] op, input logic [2:0] f3,
                                        input logic [4:0] rd, rs1, input logic [11:0] imm);
      return {imm, rs1, f3, rd, op};
   endfunction

   // Word store with base x0
   function automatic logic [31:0] encS(input logic [4:0] rs2, input logic [11:0] imm);
      return {imm[11:5], rs2, 5'd0, rvPkg::F3_WORD, imm[4:0], rvPkg::OP_STORE};
   endfunction

   function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                        input logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rvPkg::OP_BRANCH};
   endfunction

   function automatic logic [31:0] encU(input logic [6:0] op, input logic [4:0] rd,
                                        input logic [19:0] imm);
      return {imm, rd, op};
   endfunction

   function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, rvPkg::OP_JAL};
   endfunction

   function automatic void emit(input logic [31:0] word);
      prog[progLen] = word;
      progLen++;
   endfunction

   // ISA-level reference, steps until HALT and records every register write
   function automatic void runModel();
      int          pc;
      int          nextPc;
      int          steps;
      logic [31:0] ins, a, b, immI, addr, res;
      logic [2:0]  f3;
      logic        wr;
      logic        take;
      pc    = 0;
      steps = 0;
      while (prog[pc / 4] !== HALT && steps < 4000)
      begin
         ins    = prog[pc / 4];
         f3     = ins[14:12];
         a      = mregs[ins[19:15]];
         b      = mregs[ins[24:20]];
         immI   = {{20{ins[31]}}, ins[31:20]};
         addr   = a + immI;
         nextPc = pc + 4;
         wr     = 1'b1;
         res    = '0;
         case (ins[6:0])
            rvPkg::OP_REG, rvPkg::OP_IMM:
            begin
               if (ins[6:0] == rvPkg::OP_IMM)
                  b = immI;
               case (f3)
                  3'b000:  res = (ins[6:0] == rvPkg::OP_REG && ins[30]) ? a - b : a + b;
                  3'b100:  res = a ^ b;
                  3'b110:  res = a | b;
                  3'b111:  res = a & b;
                  3'b010:
                  begin
                     res = {31'b0, $signed(a) < $signed(b)};
                     // No SLTI in the subset
                     wr  = (ins[6:0] == rvPkg::OP_REG);
                  end
                  default: wr = 1'b0;
               endcase
            end
            rvPkg::OP_LUI:   res = {ins[31:12], 12'b0};
            rvPkg::OP_AUIPC: res = {ins[31:12], 12'b0} + pc;
            rvPkg::OP_JAL:
            begin
               res    = (pc + 4) & 32'hfff;
               nextPc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            rvPkg::OP_JALR:
            begin
               res    = (pc + 4) & 32'hfff;
               nextPc = addr & ~32'd1;
            end
            rvPkg::OP_BRANCH:
            begin
               wr = 1'b0;
               case (f3)
                  3'b000:  take = (a == b);
                  3'b001:  take = (a != b);
                  3'b100:  take = ($signed(a) < $signed(b));
                  3'b101:  take = ($signed(a) >= $signed(b));
                  default: take = 1'b0;
               endcase
               if (take)
                  nextPc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            rvPkg::OP_LOAD:
            begin
               wr  = (f3 == rvPkg::F3_WORD);
               res = mdmem[addr[11:2]];
            end
            rvPkg::OP_STORE:
            begin
               wr   = 1'b0;
               addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
               if (f3 == rvPkg::F3_WORD)
                  mdmem[addr[11:2]] = b;
            end
            default: wr = 1'b0;
         endcase
         if (wr && ins[11:7] != 5'd0)
         begin
            mregs[ins[11:7]] = res;
            expRd.push_back(ins[11:7]);
            expData.push_back(res);
         end
         // 12-bit program counter wraps
         pc = nextPc & 32'hfff;
         steps++;
      end
   endfunction

   function automatic void buildDirected();
      // Every register and the load window get a defined value
      for (int r = 1; r < 32; r++)
         emit(encI(rvPkg::OP_IMM, rvPkg::F3_ADD, 5'(r), 5'd0, takeBits(12)));
      for (int k = 0; k < 16; k++)
         emit(encS(5'(k + 1), 12'(256 + 4 * k)));
      // Dependent ALU chain, each operand forwarded
      emit(encU(rvPkg::OP_LUI, 5'd5, 20'h12345));
      emit(encI(rvPkg::OP_IMM, rvPkg::F3_ADD, 5'd5, 5'd5, 12'h678));
      emit(encR(rvPkg::F3_ADD, 1'b0, 5'd6, 5'd5, 5'd5));
      emit(encR(rvPkg::F3_ADD, 1'b1, 5'd7, 5'd5, 5'd6));
      emit(encR(rvPkg::F3_XOR, 1'b0, 5'd8, 5'd7, 5'd6));
      emit(encR(rvPkg::F3_OR, 1'b0, 5'd9, 5'd8, 5'd5));
      emit(encR(rvPkg::F3_AND, 1'b0, 5'd10, 5'd9, 5'd7));
      emit(encR(rvPkg::F3_SLT, 1'b0, 5'd11, 5'd7, 5'd6));
      emit(encR(rvPkg::F3_SLT, 1'b0, 5'd12, 5'd6, 5'd7));
      emit(encI(rvPkg::OP_IMM, rvPkg::F3_XOR, 5'd13, 5'd11, 12'hfff));
      emit(encI(rvPkg::OP_IMM, rvPkg::F3_OR, 5'd14, 5'd13, 12'h0f0));
      emit(encI(rvPkg::OP_IMM, rvPkg::F3_AND, 5'd15, 5'd14, 12'h7ff));
      emit(encU(rvPkg::OP_AUIPC, 5'd16, 20'h00001));
      // Write to x0 is dropped and x0 still reads zero
      emit(encI(rvPkg::OP_IMM, rvPkg::F3_ADD, 5'd0, 5'd5, 12'h005));
      emit(encR(rvPkg::F3_ADD, 1'b0, 5'd17, 5'd0, 5'd16));
      // Store and load back, load-use right after
      emit(encS(5'd6, 12'h200));
      emit(encS(5'd7, 12'h204));
      emit(encI(rvPkg::OP_LOAD, rvPkg::F3_WORD, 5'd18, 5'd0, 12'h200));
      emit(encR(rvPkg::F3_ADD, 1'b0, 5'd19, 5'd18, 5'd18));
      emit(encI(rvPkg::OP_LOAD, rvPkg::F3_WORD, 5'd20, 5'd0, 12'h204));
      emit(encS(5'd20, 12'h208));
      emit(encI(rvPkg::OP_LOAD, rvPkg::F3_WORD, 5'd21, 5'd0, 12'h208));
      // Branches, each skipped slot would retire if squashing failed
      emit(encI(rvPkg::OP_IMM, rvPkg::F3_ADD, 5'd22, 5'd0, 12'd5));
      emit(encI(rvPkg::OP_IMM, rvPkg::F3_ADD, 5'd23, 5'd0, 12'hffd));
      emit(encB(rvPkg::F3_BEQ, 5'd22, 5'd22, 13'd8));
      emit(encI(rvPkg::OP_IMM, rvPkg::F3_ADD, 5'd24, 5'd0, 12'd1));
      emit(encB(rvPkg::F3_BNE, 5'd22, 5'd22, 13'd8));
      emit(encI(rvPkg::OP_IMM, rvPkg::F3_ADD, 5'd24, 5'd0, 12'd2));
      emit(encB(rvPkg::F3_BLT, 5'd23, 5'd22, 13'd8));
      emit(encI(rvPkg::OP_IMM, rvPkg::F3_ADD, 5'd25, 5'd0, 12'd3));
      emit(encB(rvPkg::F3_BGE, 5'd23, 5'd22, 13'd8));
      emit(encI(rvPkg::OP_IMM, rvPkg::F3_ADD, 5'd25, 5'd0, 12'd4));
      emit(encB(rvPkg::F3_BLT, 5'd22, 5'd23, 13'd8));
      emit(encB(rvPkg::F3_BGE, 5'd22, 5'd23, 13'd8));
      emit(encI(rvPkg::OP_IMM, rvPkg::F3_ADD, 5'd26, 5'd0, 12'd5));
      emit(encB(rvPkg::F3_BNE, 5'd22, 5'd23, 13'd8));
      emit(encI(rvPkg::OP_IMM, rvPkg::F3_ADD, 5'd26, 5'd0, 12'd6));
      emit(encB(rvPkg::F3_BEQ, 5'd22, 5'd23, 13'd8));
      emit(encJ(5'd27, 21'd8));
      emit(encI(rvPkg::OP_IMM, rvPkg::F3_ADD, 5'd28, 5'd0, 12'd7));
      emit(encU(rvPkg::OP_AUIPC, 5'd29, 20'd0));
      // Odd JALR target, bit 0 gets cleared
      emit(encI(rvPkg::OP_JALR, 3'b000, 5'd30, 5'd29, 12'd13));
      emit(encI(rvPkg::OP_IMM, rvPkg::F3_ADD, 5'd31, 5'd0, 12'd8));
      emit(encR(rvPkg::F3_ADD, 1'b0, 5'd1, 5'd30, 5'd27));
   endfunction

   // ALU, word memory in the load window, and forward branches only
   function automatic void buildRandom(input int count);
      int         endIdx;
      int         k;
      int         idx;
      logic [2:0] kind;
      logic [2:0] f3;
      logic [4:0] rd, rs1, rs2;
      endIdx = progLen + count;
      while (progLen < endIdx)
      begin
         kind = takeBits(3);
         rd   = takeBits(5);
         rs1  = takeBits(5);
         rs2  = takeBits(5);
         case (kind)
            3'd0, 3'd1:
            begin
               f3 = ALU_F3[takeBits(3) % 5];
               emit(encR(f3, (f3 == rvPkg::F3_ADD) && takeBit(), rd, rs1, rs2));
            end
            3'd2, 3'd3:
            begin
               idx = takeBits(2);
               f3  = ALU_F3[(idx == 0) ? 0 : idx + 1];
               emit(encI(rvPkg::OP_IMM, f3, rd, rs1, takeBits(12)));
            end
            3'd4: emit(encU(takeBit() ? rvPkg::OP_AUIPC : rvPkg::OP_LUI, rd, takeBits(20)));
            3'd5: emit(encI(rvPkg::OP_LOAD, rvPkg::F3_WORD, rd, 5'd0,
                            12'(256 + 4 * takeBits(4))));
            3'd6: emit(encS(rs2, 12'(256 + 4 * takeBits(4))));
            default:
            begin
               k = 1 + takeBits(2);
               // Never jump past the closing HALT
               if (progLen + k > endIdx)
                  k = endIdx - progLen;
               emit(encB(BR_F3[takeBits(2)], rs1, rs2, 13'(4 * k)));
            end
         endcase
      end
   endfunction

   task automatic runProgram(input bit withStall);
      int total;
      int cycles;
      int limit;
      emit(HALT);
      expRd.delete();
      expData.delete();
      runModel();
      total   = expRd.size();
      limit   = 10 * total + 200;
      retired = 0;
      @(posedge clk);
      rst   <= 1'b1;
      stall <= 1'b0;
      for (int i = 0; i < progLen; i++)
      begin
         imemWe    <= 1'b1;
         imemAddr  <= 12'(4 * i);
         imemWdata <= prog[i];
         @(posedge clk);
      end
      imemWe <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst    <= 1'b0;
      cycles = 0;
      while (retired < total && cycles < limit)
      begin
         @(posedge clk);
         // Stall about one cycle in four
         if (withStall)
            stall <= (takeBits(2) == 32'd3);
         cycles++;
      end
      if (retired < total)
         failRun($sformatf("Timed out after %0d cycles with %0d of %0d writes retired",
                           cycles, retired, total));
      stall <= 1'b0;
      // Window for any stray retire after the last expected one
      repeat (8) @(posedge clk);
      progLen = 0;
   endtask

   // Outputs settle by the falling edge
   always @(negedge clk)
   begin
      if (!rst)
      begin
         if (stall)
            compareValue("retireValid", retireValid, 32'd0);
         if (retireValid === 1'b1)
         begin
            if (expRd.size() == 0)
               failRun("A register write retired after the expected sequence was used up");
            compareValue("retireRd", retireRd, expRd.pop_front());
            compareValue("retireData", retireData, expData.pop_front());
            retired++;
         end
      end
   end

   initial
   begin
      rst       = 1'b1;
      stall     = 1'b0;
      imemWe    = 1'b0;
      imemAddr  = '0;
      imemWdata = '0;
      lfsr      = LFSR_SEED;
      progLen   = 0;
      retired   = 0;
      for (int r = 0; r < 32; r++)
         mregs[r] = '0;
      for (int w = 0; w < rvPkg::DMEM_DEPTH; w++)
         mdmem[w] = '0;
      buildDirected();
      runProgram(1'b0);
      buildRandom(200);
      runProgram(1'b0);
      buildRandom(200);
      runProgram(1'b1);
      $display("TEST OK");
      $finish;
   end

endmodule

// File: flist.f
src/rvPkg.sv
src/fetchIf.sv
src/fetchUnit.sv
src/regFile.sv
src/executeUnit.sv
src/writebackUnit.sv
src/riscvCore.sv
dv/riscvCore_asserts.sv
dv/tbRiscvCore.sv

// File: Bender.yml
package:
  name: riscv_core

sources:
  - src/rvPkg.sv
  - src/fetchIf.sv
  - src/fetchUnit.sv
  - src/regFile.sv
  - src/executeUnit.sv
  - src/writebackUnit.sv
  - src/riscvCore.sv
  - target: test
    files:
      - dv/riscvCore_asserts.sv
      - dv/tbRiscvCore.sv
